// ==== flist.f ====
verilog/display_pkg.sv
verilog/stream_pkg.sv
verilog/pixel_wr_if.sv
verilog/byte_fifo.sv
verilog/pixel_assembler.sv
verilog/frame_buffer.sv
verilog/pixel_link_top.sv
sim/pixel_link_sva.sv
sim/pixel_link_checker.sv
sim/pixel_link_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the pixel link testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=pixel_link_sim

verilator --binary --assert --timing -f flist.f --top-module pixel_link_tb \
    -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$("./$BUILD_DIR/$SIM_BIN")
sim_status=$?
echo "$output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$output" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1

// ==== sim/pixel_link_checker.sv ====
`timescale 1ns/1ns

module pixel_link_checker #(
    parameter int NPIX = 32
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           req,
    input  int                             test_id,
    input  int                             exp_frames,
    input  logic [23:0]                    exp_pix [NPIX],
    output logic [display_pkg::ADDR_W-1:0] rd_addr,
    input  display_pkg::rgb888_t           rd_data,
    input  logic                           frame_done,
    input  logic [15:0]                    frame_count,
    input  logic                           overflow,
    output int                             done_cnt,
    output int                             n_pass,
    output int                             n_fail
);

    // Cycles with frame_done high since reset
    int pulses;

    always_ff @(posedge clk) begin
        if (reset) begin
            pulses <= 0;
        end else if (frame_done) begin
            pulses <= pulses + 1;
        end
    end

    function automatic string test_name(input int id);
        case (id)
            0:       return "after_reset";
            1:       return "single_frame";
            2:       return "second_frame";
            3:       return "garbage_before_sync";
            4:       return "irregular_pacing";
            default: return "no_overflow";
        endcase
    endfunction

    task automatic compare(input int id, input string what, input int exp, input int act,
                           inout int errs);
        if (exp != act) begin
            $display("CHECK FAILED test=%s %s expected=%0d actual=%0d",
                     test_name(id), what, exp, act);
            errs++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Frame readback, two cycles per word through the registered port
    //////////////////////////////////////////////////////////////////////

    task automatic read_frame(input int id, inout int errs);
        logic [23:0] got;
        int          a;
        for (a = 0; a < NPIX; a++) begin
            @(negedge clk);
            rd_addr = display_pkg::ADDR_W'(a);
            @(negedge clk);
            got = rd_data;
            if (got !== exp_pix[a]) begin
                $display("CHECK FAILED test=%s addr=%0d expected=%06h actual=%06h",
                         test_name(id), a, exp_pix[a], got);
                errs++;
            end
        end
    endtask

    task automatic run_check(input int id, input int frames);
        int errs;
        errs = 0;
        @(negedge clk);
        case (id)
            0: begin
                compare(id, "frame_done", 0, int'(frame_done), errs);
                compare(id, "frame_count", 0, int'(frame_count), errs);
                compare(id, "overflow", 0, int'(overflow), errs);
            end
            5: begin
                compare(id, "overflow", 0, int'(overflow), errs);
            end
            default: begin
                wait (pulses >= frames);
                repeat (2) @(negedge clk);
                compare(id, "frame_done pulses", frames, pulses, errs);
                compare(id, "frame_count", frames, int'(frame_count), errs);
                read_frame(id, errs);
            end
        endcase
        if (errs == 0) begin
            n_pass++;
            $display("Test %s: ok", test_name(id));
        end else begin
            n_fail++;
            $display("Test %s: %0d errors", test_name(id), errs);
        end
        done_cnt++;
    endtask

    initial begin
        rd_addr  = '0;
        done_cnt = 0;
        n_pass   = 0;
        n_fail   = 0;
        forever begin
            @(posedge clk);
            if (req) begin
                run_check(test_id, exp_frames);
            end
        end
    end

endmodule

// ==== sim/pixel_link_sva.sv ====
`timescale 1ns/1ns

module pixel_link_sva #(
    parameter int FRAME_W = 8,
    parameter int FRAME_H = 4
) (
    input logic                           clk,
    input logic                           reset,
    input logic                           empty,
    input logic                           pop,
    input logic                           wr_en,
    input logic [display_pkg::ADDR_W-1:0] wr_addr,
    input logic                           frame_end
);

    localparam int NPIX = FRAME_W * FRAME_H;

    no_pop_when_empty: assert property (@(posedge clk) disable iff (reset)
        empty |-> !pop)
        else $error("assembler popped while the FIFO was empty");

    addr_in_frame: assert property (@(posedge clk) disable iff (reset)
        wr_en |-> (int'(wr_addr) < NPIX))
        else $error("pixel write address outside the frame");

    frame_end_with_write: assert property (@(posedge clk) disable iff (reset)
        frame_end |-> wr_en)
        else $error("frame end without a pixel write");

endmodule

bind pixel_assembler pixel_link_sva #(
    .FRAME_W (FRAME_W),
    .FRAME_H (FRAME_H)
) sva0 (
    .clk       (clk),
    .reset     (reset),
    .empty     (empty),
    .pop       (pop),
    .wr_en     (wr_en_q),
    .wr_addr   (wr_addr_q),
    .frame_end (frame_end_q)
);

// ==== sim/pixel_link_tb.sv ====
`timescale 1ns/1ns

module pixel_link_tb;

    localparam int FRAME_W     = 8;
    localparam int FRAME_H     = 4;
    localparam int NPIX        = FRAME_W * FRAME_H;
    localparam int NUM_TESTS   = 6;
    localparam int GARBAGE_N   = 12;
    localparam int OVF_CYCLES  = 40;

    // Watchdog budget from the stimulus length
    localparam int TOTAL_BYTES = 4 * (1 + 3 * NPIX) + GARBAGE_N + OVF_CYCLES;
    localparam int READBACK    = 4 * 2 * NPIX + NUM_TESTS * 20;
    localparam int WATCHDOG    = 4 * TOTAL_BYTES * 2 + READBACK + 10;

    logic                           clk;
    logic                           reset;
    logic                           byte_valid;
    logic [7:0]                     byte_data;
    logic [display_pkg::ADDR_W-1:0] rd_addr;
    display_pkg::rgb888_t           rd_data;
    logic                           frame_done;
    logic [15:0]                    frame_count;
    logic                           overflow;

    // Checker handshake
    logic        req;
    int          test_id;
    int          exp_frames;
    int          checks_req;
    int          done_cnt;
    int          n_pass;
    int          n_fail;

    // Reference model, the frame as sent
    logic [23:0] model [NPIX];
    logic [31:0] rng;

    pixel_link_top #(
        .FRAME_W    (FRAME_W),
        .FRAME_H    (FRAME_H),
        .FIFO_DEPTH (16)
    ) dut0 (
        .clk         (clk),
        .reset       (reset),
        .byte_valid  (byte_valid),
        .byte_data   (byte_data),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .frame_done  (frame_done),
        .frame_count (frame_count),
        .overflow    (overflow)
    );

    pixel_link_checker #(
        .NPIX (NPIX)
    ) chk0 (
        .clk         (clk),
        .reset       (reset),
        .req         (req),
        .test_id     (test_id),
        .exp_frames  (exp_frames),
        .exp_pix     (model),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .frame_done  (frame_done),
        .frame_count (frame_count),
        .overflow    (overflow),
        .done_cnt    (done_cnt),
        .n_pass      (n_pass),
        .n_fail      (n_fail)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Stimulus, all driven on the falling edge
    //////////////////////////////////////////////////////////////////////

    // Random idle gap of 0 to max_gap cycles before the byte
    task automatic send_byte(input logic [7:0] b, input int max_gap);
        int gap;
        rng = xorshift(rng);
        gap = int'(rng[15:8]) % (max_gap + 1);
        repeat (gap) begin
            @(negedge clk);
            byte_valid = 1'b0;
        end
        @(negedge clk);
        byte_valid = 1'b1;
        byte_data  = b;
    endtask

    task automatic stop_stream();
        @(negedge clk);
        byte_valid = 1'b0;
    endtask

    task automatic send_frame(input int max_gap);
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
        int         i;
        send_byte(stream_pkg::START_BYTE, max_gap);
        for (i = 0; i < NPIX; i++) begin
            rng = xorshift(rng);
            r = rng[7:0];
            g = rng[15:8];
            b = rng[23:16];
            model[i] = {r, g, b};
            send_byte(r, max_gap);
            send_byte(g, max_gap);
            send_byte(b, max_gap);
        end
        stop_stream();
    endtask

    // Noise bytes, never the start byte
    task automatic send_garbage(input int n, input int max_gap);
        logic [7:0] b;
        int         i;
        for (i = 0; i < n; i++) begin
            rng = xorshift(rng);
            b = rng[7:0];
            if (b == stream_pkg::START_BYTE) begin
                b = 8'h55;
            end
            send_byte(b, max_gap);
        end
    endtask

    task automatic request_check(input int id, input int frames);
        @(negedge clk);
        test_id    = id;
        exp_frames = frames;
        req        = 1'b1;
        @(negedge clk);
        req = 1'b0;
        checks_req++;
        wait (done_cnt == checks_req);
    endtask

    initial begin
        reset      = 1'b1;
        byte_valid = 1'b0;
        byte_data  = 8'h00;
        req        = 1'b0;
        test_id    = 0;
        exp_frames = 0;
        checks_req = 0;
        rng        = 32'd59;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        request_check(0, 0);
        send_frame(2);
        request_check(1, 1);
        send_frame(2);
        request_check(2, 2);
        send_garbage(GARBAGE_N, 2);
        send_frame(2);
        request_check(3, 3);
        send_frame(5);
        request_check(4, 4);

        // Back to back bytes, the assembler drains one per cycle
        send_garbage(OVF_CYCLES, 0);
        stop_stream();
        repeat (4) @(negedge clk);
        request_check(5, 4);

        $display("Tests run: %0d, passed: %0d, failed: %0d", n_pass + n_fail, n_pass, n_fail);
        if (n_fail == 0 && n_pass == NUM_TESTS) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the tests did not complete", WATCHDOG);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== verilog/byte_fifo.sv ====
`timescale 1ns/1ns

module byte_fifo #(
    parameter int DEPTH = 16
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       push,
    input  logic [7:0] push_data,
    input  logic       pop,
    output logic       empty,
    output logic [7:0] head_data,
    output logic       overflow
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [7:0]       mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             do_push;
    logic             do_pop;

    // Pointer step with wrap at the last slot, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full    = (count == CNT_W'(DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Show-ahead head, no read latency
    assign head_data = mem[rd_ptr];

    //////////////////////////////////////////////////////////////////////
    // Pointers, occupancy, overflow
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Sticky until reset
            if (push && full) begin
                overflow <= 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

// ==== verilog/display_pkg.sv ====
package display_pkg;

    //////////////////////////////////////////////////////////////////////
    // Panel geometry
    //////////////////////////////////////////////////////////////////////

    // Default panel size, 172 columns by 240 rows
    localparam int FRAME_W_DEF = 172;
    localparam int FRAME_H_DEF = 240;

    // Linear pixel address width, covers 172 * 240 = 41280 words
    localparam int ADDR_W = 16;

    //////////////////////////////////////////////////////////////////////
    // Pixel format
    //////////////////////////////////////////////////////////////////////

    // RGB888 word, red in the top byte
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb888_t;

endpackage

// ==== verilog/frame_buffer.sv ====
`timescale 1ns/1ns

module frame_buffer #(
    parameter int FRAME_W = 172,
    parameter int FRAME_H = 240
) (
    input  logic                           clk,
    input  logic                           reset,
    pixel_wr_if.sink                       wr,
    input  logic [display_pkg::ADDR_W-1:0] rd_addr,
    output display_pkg::rgb888_t           rd_data,
    output logic                           frame_done,
    output logic [15:0]                    frame_count
);

    localparam int DEPTH = FRAME_W * FRAME_H;
    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    display_pkg::rgb888_t mem [DEPTH];

    //////////////////////////////////////////////////////////////////////
    // Pixel RAM, write from the assembler and registered read
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wr.wr_en) begin
            mem[wr.wr_addr[IDX_W-1:0]] <= wr.wr_pixel;
        end
        rd_data <= mem[rd_addr[IDX_W-1:0]];
    end

    // Frame completion, one cycle after the last write
    always_ff @(posedge clk) begin
        if (reset) begin
            frame_done  <= 1'b0;
            frame_count <= '0;
        end else begin
            frame_done <= wr.frame_end;
            if (wr.frame_end) begin
                frame_count <= frame_count + 1'b1;
            end
        end
    end

endmodule

// ==== verilog/pixel_assembler.sv ====
`timescale 1ns/1ns

module pixel_assembler #(
    parameter int FRAME_W = 172,
    parameter int FRAME_H = 240
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        empty,
    input  logic [7:0]  head_data,
    output logic        pop,
    pixel_wr_if.source  wr
);

    localparam int ADDR_W = display_pkg::ADDR_W;
    localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(FRAME_W * FRAME_H - 1);

    stream_pkg::asm_state_t state;

    // Colour bytes held until the blue byte arrives
    logic [7:0]           red_q;
    logic [7:0]           green_q;

    // Address of the next pixel in the frame
    logic [ADDR_W-1:0]    pixel_cnt;

    // Registered write towards the frame buffer
    logic                 wr_en_q;
    logic [ADDR_W-1:0]    wr_addr_q;
    display_pkg::rgb888_t wr_pixel_q;
    logic                 frame_end_q;

    // Drain one byte every cycle something is waiting
    assign pop = !empty;

    //////////////////////////////////////////////////////////////////////
    // Framing FSM and pixel counter
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= stream_pkg::HUNT;
            pixel_cnt   <= '0;
            wr_en_q     <= 1'b0;
            frame_end_q <= 1'b0;
        end else begin
            wr_en_q     <= 1'b0;
            frame_end_q <= 1'b0;
            if (pop) begin
                case (state)
                    stream_pkg::HUNT: begin
                        // Anything but the start byte is thrown away
                        if (head_data == stream_pkg::START_BYTE) begin
                            state <= stream_pkg::RED;
                        end
                    end
                    stream_pkg::RED: begin
                        state <= stream_pkg::GREEN;
                    end
                    stream_pkg::GREEN: begin
                        state <= stream_pkg::BLUE;
                    end
                    stream_pkg::BLUE: begin
                        wr_en_q <= 1'b1;
                        if (pixel_cnt == LAST_ADDR) begin
                            // Last pixel of the frame, back to sync search
                            frame_end_q <= 1'b1;
                            pixel_cnt   <= '0;
                            state       <= stream_pkg::HUNT;
                        end else begin
                            pixel_cnt <= pixel_cnt + 1'b1;
                            state     <= stream_pkg::RED;
                        end
                    end
                    default: begin
                        state <= stream_pkg::HUNT;
                    end
                endcase
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Colour capture and write payload
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (pop) begin
            case (state)
                stream_pkg::RED: begin
                    red_q <= head_data;
                end
                stream_pkg::GREEN: begin
                    green_q <= head_data;
                end
                stream_pkg::BLUE: begin
                    wr_pixel_q.red   <= red_q;
                    wr_pixel_q.green <= green_q;
                    wr_pixel_q.blue  <= head_data;
                    wr_addr_q        <= pixel_cnt;
                end
                default: begin
                    red_q <= red_q;
                end
            endcase
        end
    end

    assign wr.wr_en     = wr_en_q;
    assign wr.wr_addr   = wr_addr_q;
    assign wr.wr_pixel  = wr_pixel_q;
    assign wr.frame_end = frame_end_q;

endmodule

// ==== verilog/pixel_link_top.sv ====
`timescale 1ns/1ns

module pixel_link_top #(
    parameter int FRAME_W    = display_pkg::FRAME_W_DEF,
    parameter int FRAME_H    = display_pkg::FRAME_H_DEF,
    parameter int FIFO_DEPTH = stream_pkg::FIFO_DEPTH_DEF
) (
    input  logic                           clk,
    input  logic                           reset,

    // Host byte stream
    input  logic                           byte_valid,
    input  logic [7:0]                     byte_data,

    // Frame readout and status
    input  logic [display_pkg::ADDR_W-1:0] rd_addr,
    output display_pkg::rgb888_t           rd_data,
    output logic                           frame_done,
    output logic [15:0]                    frame_count,
    output logic                           overflow
);

    // Byte path between FIFO and assembler
    logic       fifo_empty;
    logic [7:0] fifo_head;
    logic       fifo_pop;

    pixel_wr_if wr_bus ();

    //////////////////////////////////////////////////////////////////////
    // Input side
    //////////////////////////////////////////////////////////////////////

    byte_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk       (clk),
        .reset     (reset),
        .push      (byte_valid),
        .push_data (byte_data),
        .pop       (fifo_pop),
        .empty     (fifo_empty),
        .head_data (fifo_head),
        .overflow  (overflow)
    );

    //////////////////////////////////////////////////////////////////////
    // Pixel assembly and storage
    //////////////////////////////////////////////////////////////////////

    pixel_assembler #(
        .FRAME_W (FRAME_W),
        .FRAME_H (FRAME_H)
    ) u_assembler (
        .clk       (clk),
        .reset     (reset),
        .empty     (fifo_empty),
        .head_data (fifo_head),
        .pop       (fifo_pop),
        .wr        (wr_bus.source)
    );

    frame_buffer #(
        .FRAME_W (FRAME_W),
        .FRAME_H (FRAME_H)
    ) u_frame_buffer (
        .clk         (clk),
        .reset       (reset),
        .wr          (wr_bus.sink),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .frame_done  (frame_done),
        .frame_count (frame_count)
    );

endmodule

// ==== verilog/pixel_wr_if.sv ====
`timescale 1ns/1ns

interface pixel_wr_if;

    // One write per completed pixel
    logic                             wr_en;
    logic [display_pkg::ADDR_W-1:0]   wr_addr;
    display_pkg::rgb888_t             wr_pixel;

    // High with the write of the last pixel in a frame
    logic                             frame_end;

    // Assembler side
    modport source (
        output wr_en,
        output wr_addr,
        output wr_pixel,
        output frame_end
    );

    // Frame buffer side
    modport sink (
        input wr_en,
        input wr_addr,
        input wr_pixel,
        input frame_end
    );

endinterface

// ==== verilog/stream_pkg.sv ====
package stream_pkg;

    //////////////////////////////////////////////////////////////////////
    // Byte stream framing
    //////////////////////////////////////////////////////////////////////

    // Marks the beginning of a frame
    localparam logic [7:0] START_BYTE = 8'hAA;

    // Default input FIFO depth in bytes
    localparam int FIFO_DEPTH_DEF = 16;

    //////////////////////////////////////////////////////////////////////
    // Assembler states
    //////////////////////////////////////////////////////////////////////

    // HUNT waits for the start byte, the others name the next byte expected
    typedef enum logic [1:0] {
        HUNT,
        RED,
        GREEN,
        BLUE
    } asm_state_t;

endpackage
